// ==== design/memPkg.sv ====
package memPkg;

  // ==============================
  // basic widths
  // ==============================
  typedef logic [31:0] dataT;     // one memory word
  typedef logic [31:0] byteAddrT; // core-side byte address
  typedef logic [3:0]  byteSelT;  // one bit per byte lane

  // load/store access size, code 3 is unused and handled as a word
  typedef enum logic [1:0] {
    sizeWord = 2'd0, // reset value of the lane pipeline
    sizeHalf = 2'd1,
    sizeByte = 2'd2
  } accessSizeT;

  // ==============================
  // request from a core to its lane
  // ==============================
  typedef struct packed {
    logic       writeEn;   // store this cycle
    logic       readEn;    // load this cycle
    accessSizeT size;      // word, half or byte
    byteSelT    byteSel;   // store byte enables
    byteAddrT   byteAddr;  // full byte address
    dataT       storeData; // store payload
  } memReqT;

  // ==============================
  // lane to memory
  // ==============================
  // word address goes on its own port,
  // its width differs between CP and PE lanes
  typedef struct packed {
    logic    valid;     // any access this cycle
    logic    writeEn;
    logic    readEn;
    byteSelT byteSel;
    dataT    writeData;
  } memBusT;

  // half-word and byte field widths used by the aligner
  localparam int HalfBits = 16;
  localparam int ByteBits = 8;

endpackage

// ==== design/sregPkg.sv ====
package sregPkg;

  // ==============================
  // special register region
  // ==============================
  // region is 0xFFFF_FF00 .. 0xFFFF_FFFF
  // all of byteAddr[31:8] must be set
  localparam logic [23:0] sregRegionMask = 24'hFF_FFFF;

  // offsets inside the region (byteAddr[7:0])
  localparam logic [7:0] sregFirstOffset = 8'h00; // first PE boundary mode
  localparam logic [7:0] sregLastOffset  = 8'h04; // last PE boundary mode

  // ==============================
  // boundary mode
  // ==============================
  // selects what the edge PEs see past the array end
  typedef logic [1:0] boundaryModeT;

  localparam boundaryModeT boundaryModeZero = 2'b00; // reset value

endpackage

// ==== design/memLane.sv ====
`timescale 1ns/1ps

// one data-memory lane
// byte address -> word address, plus load alignment one cycle later
module memLane import memPkg::*; #(
  parameter int RamAddrBits = 8 // word address width of this lane's memory
) (
  input  logic                   iClk,
  input  logic                   rst,
  input  memReqT                 req,      // from core (already gated)
  output memBusT                 bus,      // to memory
  output logic [RamAddrBits-1:0] wordAddr, // to memory
  input  dataT                   rawData,  // memory read data, one cycle late
  output dataT                   loadData  // aligned, zero-extended
);

  accessSizeT sizeReg;   // size of the read in flight
  logic [1:0] offsetReg; // byte offset of the read in flight

  // ==============================
  // request side, combinational
  // ==============================
  always_comb begin
    bus.valid     = req.readEn | req.writeEn;
    bus.writeEn   = req.writeEn;
    bus.readEn    = req.readEn;
    bus.byteSel   = req.byteSel;   // straight through
    bus.writeData = req.storeData; // straight through
  end

  // drop the byte offset
  assign wordAddr = req.byteAddr[RamAddrBits+1:2];

  // ==============================
  // read pipeline register
  // ==============================
  // only loaded on reads, so the
  // result holds until the next read
  always_ff @(posedge iClk) begin
    if (rst) begin
      sizeReg   <= sizeWord;
      offsetReg <= 2'b00;
    end else if (req.readEn) begin
      sizeReg   <= req.size;
      offsetReg <= req.byteAddr[1:0];
    end
  end

  // ==============================
  // load alignment
  // ==============================
  always_comb begin
    case (sizeReg)
      sizeHalf: begin
        // bit 1 picks the half, bit 0 ignored
        if (offsetReg[1]) begin
          loadData = {{HalfBits{1'b0}}, rawData[31:16]};
        end else begin
          loadData = {{HalfBits{1'b0}}, rawData[15:0]};
        end
      end
      sizeByte: begin
        case (offsetReg)
          2'b00:   loadData = {{(32-ByteBits){1'b0}}, rawData[7:0]};
          2'b01:   loadData = {{(32-ByteBits){1'b0}}, rawData[15:8]};
          2'b10:   loadData = {{(32-ByteBits){1'b0}}, rawData[23:16]};
          default: loadData = {{(32-ByteBits){1'b0}}, rawData[31:24]};
        endcase
      end
      default: begin
        loadData = rawData; // word and the unused code
      end
    endcase
  end

endmodule

// ==== design/boundaryRegs.sv ====
`timescale 1ns/1ps

// the two memory-mapped boundary-mode registers
// write lands next cycle, read data is registered
module boundaryRegs import memPkg::*; import sregPkg::*; (
  input  logic         iClk,
  input  logic         rst,
  input  logic         wrEn,      // special write, already decoded
  input  logic         rdEn,      // special read, already decoded
  input  logic [7:0]   offset,    // byteAddr[7:0]
  input  boundaryModeT wrData,
  output dataT         rdData,    // valid the cycle after rdEn
  output boundaryModeT modeFirst, // to first PE
  output boundaryModeT modeLast   // to last PE
);

  // ==============================
  // register write
  // ==============================
  always_ff @(posedge iClk) begin
    if (rst) begin
      modeFirst <= boundaryModeZero;
      modeLast  <= boundaryModeZero;
    end else if (wrEn) begin
      if (offset == sregFirstOffset) begin
        modeFirst <= wrData;
      end
      if (offset == sregLastOffset) begin
        modeLast <= wrData;
      end
      // other offsets dropped
    end
  end

  // ==============================
  // register read
  // ==============================
  // anything but the first offset reads
  // back the last-PE mode
  always_ff @(posedge iClk) begin
    if (rst) begin
      rdData <= '0;
    end else if (rdEn) begin
      if (offset == sregFirstOffset) begin
        rdData <= {30'b0, modeFirst};
      end else begin
        rdData <= {30'b0, modeLast};
      end
    end
  end

endmodule

// ==== design/cpAccessRouter.sv ====
`timescale 1ns/1ps

// CP data-memory lane with the special register region on top
module cpAccessRouter import memPkg::*; import sregPkg::*; #(
  parameter int RamAddrBits = 10 // CP word address width
) (
  input  logic                   iClk,
  input  logic                   rst,
  input  memReqT                 req,       // from CP core side
  output memBusT                 bus,       // to CP memory
  output logic [RamAddrBits-1:0] wordAddr,
  input  dataT                   rawData,   // CP memory read data
  output dataT                   loadData,  // back to CP core side
  output boundaryModeT           modeFirst, // to PE array
  output boundaryModeT           modeLast
);

  logic   special;      // request hits the special region
  logic   specialReg;   // read in flight was special
  memReqT laneReq;      // request with gated write
  dataT   laneLoadData; // aligned memory data
  dataT   sregRdData;   // registered special read

  // ==============================
  // region decode
  // ==============================
  assign special = ((req.byteAddr[31:8] & sregRegionMask) == sregRegionMask);

  // keep special writes off the memory bus,
  // reads still go out to memory
  always_comb begin
    laneReq         = req;
    laneReq.writeEn = req.writeEn & ~special;
  end

  memLane #(
    .RamAddrBits(RamAddrBits)
  ) u_cpLane (
    .iClk    (iClk),
    .rst     (rst),
    .req     (laneReq),
    .bus     (bus),
    .wordAddr(wordAddr),
    .rawData (rawData),
    .loadData(laneLoadData)
  );

  boundaryRegs u_boundaryRegs (
    .iClk     (iClk),
    .rst      (rst),
    .wrEn     (req.writeEn & special),
    .rdEn     (req.readEn & special),
    .offset   (req.byteAddr[7:0]),
    .wrData   (req.storeData[1:0]), // mode is the low two bits
    .rdData   (sregRdData),
    .modeFirst(modeFirst),
    .modeLast (modeLast)
  );

  // ==============================
  // read data select
  // ==============================
  // special flag follows the lane's own read register
  always_ff @(posedge iClk) begin
    if (rst) begin
      specialReg <= 1'b0;
    end else if (req.readEn) begin
      specialReg <= special;
    end
  end

  assign loadData = specialReg ? sregRdData : laneLoadData;

endmodule

// ==== design/simdDmemPort.sv ====
`timescale 1ns/1ps

// data-memory glue of the SIMD core
// one CP lane with special registers, NumPe plain PE lanes
module simdDmemPort import memPkg::*; import sregPkg::*; #(
  parameter int NumPe         = 4,  // PE lane count
  parameter int CpRamAddrBits = 10, // CP memory word address width
  parameter int PeRamAddrBits = 8   // PE memory word address width
) (
  input  logic                                 iClk,
  input  logic                                 rst,

  // ==============================
  // CP lane
  // ==============================
  input  memReqT                               cpReq,
  output memBusT                               cpBus,
  output logic [CpRamAddrBits-1:0]             cpWordAddr,
  input  dataT                                 cpRawData,
  output dataT                                 cpLoadData,

  // ==============================
  // PE lanes
  // ==============================
  input  memReqT [NumPe-1:0]                   peReq,
  output memBusT [NumPe-1:0]                   peBus,
  output logic   [NumPe-1:0][PeRamAddrBits-1:0] peWordAddr,
  input  dataT   [NumPe-1:0]                   peRawData,
  output dataT   [NumPe-1:0]                   peLoadData,

  // boundary modes out to the PE array
  output boundaryModeT                         boundaryModeFirst,
  output boundaryModeT                         boundaryModeLast
);

  // CP side, owns the special registers
  cpAccessRouter #(
    .RamAddrBits(CpRamAddrBits)
  ) u_cpAccessRouter (
    .iClk     (iClk),
    .rst      (rst),
    .req      (cpReq),
    .bus      (cpBus),
    .wordAddr (cpWordAddr),
    .rawData  (cpRawData),
    .loadData (cpLoadData),
    .modeFirst(boundaryModeFirst),
    .modeLast (boundaryModeLast)
  );

  // one plain lane per PE
  for (genvar i = 0; i < NumPe; i++) begin : genPeLane
    memLane #(
      .RamAddrBits(PeRamAddrBits)
    ) u_peLane (
      .iClk    (iClk),
      .rst     (rst),
      .req     (peReq[i]),
      .bus     (peBus[i]),
      .wordAddr(peWordAddr[i]),
      .rawData (peRawData[i]),
      .loadData(peLoadData[i])
    );
  end

endmodule

// ==== verif/simdDmemPort_chk.sv ====
`timescale 1ns/1ps

// memory-side rules of simdDmemPort, bound into the DUT
module simdDmemPort_chk import memPkg::*; import sregPkg::*; #(
  parameter int NumPe = 4
) (
  input logic               iClk,
  input logic               rst,
  input memReqT             cpReq,
  input memBusT             cpBus,
  input memBusT [NumPe-1:0] peBus,
  input boundaryModeT       boundaryModeFirst,
  input boundaryModeT       boundaryModeLast
);

  logic cpSpecial;   // CP request hits the special region
  logic cpSpecialWr; // special register write this cycle

  assign cpSpecial   = (cpReq.byteAddr[31:8] == sregRegionMask);
  assign cpSpecialWr = cpReq.writeEn & cpSpecial;

  // ==============================
  // valid vs enables
  // ==============================
  cpValidA: assert property (@(posedge iClk) disable iff (rst)
    cpBus.valid == (cpBus.readEn | cpBus.writeEn))
    else $error("CP lane valid does not match its enables");

  for (genvar i = 0; i < NumPe; i++) begin : genPeValid
    peValidA: assert property (@(posedge iClk) disable iff (rst)
      peBus[i].valid == (peBus[i].readEn | peBus[i].writeEn))
      else $error("PE lane %0d valid does not match its enables", i);
  end

  // ==============================
  // special region
  // ==============================
  cpSpecialWrA: assert property (@(posedge iClk) disable iff (rst)
    cpSpecial |-> !cpBus.writeEn)
    else $error("CP memory write enabled for a special register address");

  // modes only move one cycle after a special write
  modeStableA: assert property (@(posedge iClk) disable iff (rst)
    !$past(cpSpecialWr) |-> ($stable(boundaryModeFirst) && $stable(boundaryModeLast)))
    else $error("boundary mode changed without a special register write");

endmodule

bind simdDmemPort simdDmemPort_chk #(
  .NumPe(NumPe)
) u_simdDmemPortChk (
  .iClk             (iClk),
  .rst              (rst),
  .cpReq            (cpReq),
  .cpBus            (cpBus),
  .peBus            (peBus),
  .boundaryModeFirst(boundaryModeFirst),
  .boundaryModeLast (boundaryModeLast)
);

// ==== verif/tbSimdDmemPort.sv ====
`timescale 1ns/1ps

module tbSimdDmemPort import memPkg::*; import sregPkg::*; ();

  localparam int NumPe         = 4;  // DUT defaults
  localparam int CpRamAddrBits = 10;
  localparam int PeRamAddrBits = 8;
  localparam int CpLane        = NumPe; // table lane number of the CP
  localparam int CpWords       = 1 << CpRamAddrBits;
  localparam int PeWords       = 1 << PeRamAddrBits;
  localparam int MaxCycles     = 1000;
  localparam byteAddrT SregBase = {sregRegionMask, 8'h00};

  typedef enum logic [1:0] {opIdle, opWrite, opRead} opT;

  typedef struct {
    int         lane;    // PE index, or CpLane
    opT         op;
    accessSizeT size;
    byteAddrT   addr;
    dataT       wrData;
    dataT       expLoad; // aligned result one cycle after a read
  } stepT;

  logic                                iClk = 1'b0;
  logic                                rst;
  memReqT                              cpReq;
  memBusT                              cpBus;
  logic [CpRamAddrBits-1:0]            cpWordAddr;
  dataT                                cpRawData;
  dataT                                cpLoadData;
  memReqT [NumPe-1:0]                  peReq;
  memBusT [NumPe-1:0]                  peBus;
  logic   [NumPe-1:0][PeRamAddrBits-1:0] peWordAddr;
  dataT   [NumPe-1:0]                  peRawData;
  dataT   [NumPe-1:0]                  peLoadData;
  boundaryModeT                        boundaryModeFirst;
  boundaryModeT                        boundaryModeLast;

  stepT         steps[$];
  dataT         expLoad [NumPe+1];  // last read result per lane
  boundaryModeT modelFirst;         // expected boundary outputs
  boundaryModeT modelLast;
  int           checkCount = 0;
  int           errorCount = 0;

  always #10 iClk = ~iClk; // 20 ns period

  simdDmemPort u_simdDmemPort (
    .iClk             (iClk),
    .rst              (rst),
    .cpReq            (cpReq),
    .cpBus            (cpBus),
    .cpWordAddr       (cpWordAddr),
    .cpRawData        (cpRawData),
    .cpLoadData       (cpLoadData),
    .peReq            (peReq),
    .peBus            (peBus),
    .peWordAddr       (peWordAddr),
    .peRawData        (peRawData),
    .peLoadData       (peLoadData),
    .boundaryModeFirst(boundaryModeFirst),
    .boundaryModeLast (boundaryModeLast)
  );

  // ==============================
  // memory models
  // ==============================
  function automatic dataT mergeBytes(dataT oldWord, dataT newWord, byteSelT sel);
    dataT merged;
    merged = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) merged[8*b +: 8] = newWord[8*b +: 8];
    end
    return merged;
  endfunction

  // sync RAM, read word registered on the rising edge
  dataT cpMem [CpWords];
  dataT cpRdWord = '0;
  assign cpRawData = cpRdWord;

  always @(posedge iClk) begin
    if (rst) begin
      for (int w = 0; w < CpWords; w++) cpMem[w] = $urandom(); // random fill
      cpRdWord <= '0;
    end else if (cpBus.valid) begin
      if (cpBus.readEn) cpRdWord <= cpMem[cpWordAddr];
      if (cpBus.writeEn) begin
        cpMem[cpWordAddr] = mergeBytes(cpMem[cpWordAddr], cpBus.writeData, cpBus.byteSel);
      end
    end
  end

  for (genvar i = 0; i < NumPe; i++) begin : genPeMem
    dataT mem [PeWords];
    dataT rdWord = '0;
    assign peRawData[i] = rdWord;

    always @(posedge iClk) begin
      if (rst) begin
        for (int w = 0; w < PeWords; w++) mem[w] = $urandom();
        rdWord <= '0;
      end else if (peBus[i].valid) begin
        if (peBus[i].readEn) rdWord <= mem[peWordAddr[i]];
        if (peBus[i].writeEn) begin
          mem[peWordAddr[i]] = mergeBytes(mem[peWordAddr[i]], peBus[i].writeData,
                                          peBus[i].byteSel);
        end
      end
    end
  end

  // ==============================
  // helpers
  // ==============================
  task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic isSpecial(byteAddrT addr);
    return addr[31:8] == sregRegionMask;
  endfunction

  // field at byte offset off, zero-extended
  function automatic dataT fieldOf(dataT word, accessSizeT size, logic [1:0] off);
    dataT shifted;
    shifted = word >> {off, 3'b000};
    if (size == sizeHalf) return shifted & 32'h0000_FFFF;
    if (size == sizeByte) return shifted & 32'h0000_00FF;
    return word;
  endfunction

  function automatic logic [31:0] expWordAddr(int lane, byteAddrT addr);
    int bits;
    bits = (lane == CpLane) ? CpRamAddrBits : PeRamAddrBits;
    return (addr >> 2) & ((32'd1 << bits) - 32'd1);
  endfunction

  function automatic memBusT laneBus(int lane);
    if (lane == CpLane) return cpBus;
    return peBus[lane];
  endfunction

  function automatic logic [31:0] laneWordAddr(int lane);
    if (lane == CpLane) return 32'(cpWordAddr);
    return 32'(peWordAddr[lane]);
  endfunction

  function automatic dataT laneLoad(int lane);
    if (lane == CpLane) return cpLoadData;
    return peLoadData[lane];
  endfunction

  function automatic byteAddrT lowAddr(int lane);
    return byteAddrT'(32'h40 + 16 * lane);
  endfunction

  // bit 16 sits above every word address and must drop out
  function automatic byteAddrT highAddr(int lane);
    return byteAddrT'(32'h0001_03F0 + 4 * lane);
  endfunction

  task automatic addStep(int lane, opT op, accessSizeT size, byteAddrT addr,
                         dataT wrData, dataT expected);
    stepT s;
    s.lane    = lane;
    s.op      = op;
    s.size    = size;
    s.addr    = addr;
    s.wrData  = wrData;
    s.expLoad = expected;
    steps.push_back(s);
  endtask

  // ==============================
  // stimulus table
  // ==============================
  task automatic buildTable();
    dataT w0 [NumPe+1];
    dataT w1 [NumPe+1];
    for (int l = 0; l <= NumPe; l++) begin
      w0[l] = $urandom();
      w1[l] = $urandom();
      addStep(l, opWrite, sizeWord, lowAddr(l), w0[l], '0);
      addStep(l, opWrite, sizeWord, highAddr(l), w1[l], '0);
    end
    for (int l = 0; l <= NumPe; l++) begin
      addStep(l, opRead, sizeWord, lowAddr(l), '0, w0[l]);
      addStep(l, opRead, sizeWord, highAddr(l), '0, w1[l]);
    end
    // mixed sizes back to back, then a hold over an idle cycle
    for (int l = 0; l <= NumPe; l++) begin
      addStep(l, opRead, sizeHalf, lowAddr(l), '0, fieldOf(w0[l], sizeHalf, 2'd0));
      addStep(l, opRead, sizeHalf, lowAddr(l) + 2, '0, fieldOf(w0[l], sizeHalf, 2'd2));
      for (int b = 0; b < 4; b++) begin
        addStep(l, opRead, sizeByte, lowAddr(l) + 32'(b), '0,
                fieldOf(w0[l], sizeByte, 2'(b)));
      end
      addStep(l, opRead, sizeWord, lowAddr(l), '0, w0[l]);
      addStep(l, opIdle, sizeWord, '0, '0, '0);
      addStep(l, opRead, sizeByte, highAddr(l) + 3, '0, fieldOf(w1[l], sizeByte, 2'd3));
    end
    // special region, offset 0x08 holds no register
    addStep(CpLane, opWrite, sizeWord, SregBase | 32'(sregFirstOffset), 32'h2, '0);
    addStep(CpLane, opWrite, sizeWord, SregBase | 32'(sregLastOffset), 32'h1, '0);
    addStep(CpLane, opWrite, sizeWord, SregBase | 32'h08, 32'h3, '0);
    addStep(CpLane, opRead, sizeWord, SregBase | 32'(sregFirstOffset), '0, 32'h2);
    addStep(CpLane, opRead, sizeWord, SregBase | 32'(sregLastOffset), '0, 32'h1);
    addStep(CpLane, opRead, sizeWord, SregBase | 32'h10, '0, 32'h1); // falls to last mode
    addStep(CpLane, opRead, sizeWord, lowAddr(CpLane), '0, w0[CpLane]); // memory again
    addStep(CpLane, opWrite, sizeWord, SregBase | 32'(sregLastOffset), 32'h3, '0);
    addStep(CpLane, opRead, sizeWord, SregBase | 32'(sregLastOffset), '0, 32'h3);
    addStep(CpLane, opWrite, sizeWord, SregBase | 32'(sregFirstOffset), 32'h0, '0);
    addStep(CpLane, opRead, sizeWord, SregBase | 32'(sregFirstOffset), '0, 32'h0);
    addStep(CpLane, opIdle, sizeWord, '0, '0, '0);
  endtask

  // ==============================
  // drive and check
  // ==============================
  task automatic driveStep(stepT s);
    memReqT r;
    r.writeEn   = (s.op == opWrite);
    r.readEn    = (s.op == opRead);
    r.size      = s.size;
    r.byteSel   = (s.op == opWrite) ? 4'hF : 4'h0;
    r.byteAddr  = s.addr;
    r.storeData = s.wrData;
    cpReq = '0;
    peReq = '0;
    if (s.lane == CpLane) cpReq = r;
    else peReq[s.lane] = r;
  endtask

  // outputs that only move on a clock edge
  task automatic checkHeld();
    checkValue("boundaryModeFirst", 32'(boundaryModeFirst), 32'(modelFirst));
    checkValue("boundaryModeLast", 32'(boundaryModeLast), 32'(modelLast));
    for (int l = 0; l <= NumPe; l++) begin
      checkValue($sformatf("lane %0d loadData", l), laneLoad(l), expLoad[l]);
    end
  endtask

  task automatic checkRequestSide(stepT s);
    memBusT  b;
    logic    expWr;
    logic    expRd;
    byteSelT expSel;
    for (int l = 0; l <= NumPe; l++) begin
      b      = laneBus(l);
      expRd  = (l == s.lane) && (s.op == opRead);
      expWr  = (l == s.lane) && (s.op == opWrite) && !((l == CpLane) && isSpecial(s.addr));
      expSel = ((l == s.lane) && (s.op == opWrite)) ? 4'hF : 4'h0; // passes through ungated
      checkValue($sformatf("lane %0d valid", l), 32'(b.valid), 32'(expRd | expWr));
      checkValue($sformatf("lane %0d writeEn", l), 32'(b.writeEn), 32'(expWr));
      checkValue($sformatf("lane %0d readEn", l), 32'(b.readEn), 32'(expRd));
      checkValue($sformatf("lane %0d byteSel", l), 32'(b.byteSel), 32'(expSel));
      if (l == s.lane && s.op != opIdle) begin
        checkValue($sformatf("lane %0d wordAddr", l), laneWordAddr(l), expWordAddr(l, s.addr));
      end
      if (expWr) checkValue($sformatf("lane %0d writeData", l), b.writeData, s.wrData);
    end
  endtask

  task automatic waitBusIdle(int limit);
    int n;
    n = 0;
    while ((cpBus.valid || (peBus != '0)) && n < limit) begin // bounded wait
      @(negedge iClk);
      n++;
    end
    if (cpBus.valid || (peBus != '0)) begin
      errorCount++;
      $display("memory buses still active %0d cycles after the last request", limit);
    end
  endtask

  initial begin : watchdog
    for (int c = 0; c < MaxCycles; c++) @(posedge iClk);
    $display("timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    stepT idle;
    void'($urandom(32'ha7b8));
    idle  = '{lane: 0, op: opIdle, size: sizeWord, addr: '0, wrData: '0, expLoad: '0};
    cpReq = '0;
    peReq = '0;
    rst   = 1'b1;
    modelFirst = boundaryModeZero;
    modelLast  = boundaryModeZero;
    for (int l = 0; l <= NumPe; l++) begin
      expLoad[l] = '0;   // word size, offset 0, raw data 0 after reset
    end
    repeat (4) @(negedge iClk);
    rst = 1'b0;
    #1;
    checkHeld();
    checkRequestSide(idle);
    buildTable();
    foreach (steps[i]) begin
      @(negedge iClk);
      checkHeld();
      driveStep(steps[i]);
      #1;
      checkRequestSide(steps[i]);
      if (steps[i].op == opRead) expLoad[steps[i].lane] = steps[i].expLoad;
      if (steps[i].op == opWrite && steps[i].lane == CpLane && isSpecial(steps[i].addr)) begin
        if (steps[i].addr[7:0] == sregFirstOffset) modelFirst = steps[i].wrData[1:0];
        if (steps[i].addr[7:0] == sregLastOffset) modelLast = steps[i].wrData[1:0];
      end
    end
    @(negedge iClk);
    checkHeld();
    driveStep(idle);
    #1;
    waitBusIdle(8);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/memPkg.sv
design/sregPkg.sv
design/memLane.sv
design/boundaryRegs.sv
design/cpAccessRouter.sv
design/simdDmemPort.sv
verif/simdDmemPort_chk.sv
verif/tbSimdDmemPort.sv

// ==== Makefile ====
# Verilator build and run of the simdDmemPort testbench

TOP := tbSimdDmemPort

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module $(TOP) -f filelist.f -Mdir obj_dir -o $(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
